// File: input_settings.svh
`ifndef INPUT_SETTINGS_SVH
`define INPUT_SETTINGS_SVH

// game button count, fire 1 is always the lowest button
`define INPUT_BUTTONS 2

// 1 when the core expects pressed = 0
`define INPUT_ACTIVE_LOW 1

`define INPUT_PLAYERS 4

// width of one game joystick word
`define INPUT_LANE_BITS 10

// board word layout, control bits sit just above the buttons
`define INPUT_START_BIT (`INPUT_BUTTONS + 4)
`define INPUT_COIN_BIT  (`INPUT_BUTTONS + 5)
`define INPUT_PAUSE_BIT (`INPUT_BUTTONS + 6)

`endif

// File: input_pkg.sv
`default_nettype none

`include "input_settings.svh"

package input_pkg;

    // one board controller word, seen per field by the lanes
    // and as a flat vector by the drain
    typedef struct packed {
        logic [5:0] upper;    // extra board bits, not used by games
        logic [5:0] buttons;  // buttons[0] is fire 1
        logic [3:0] dirs;     // up, down, left, right
    } board_fields_t;

    typedef union packed {
        board_fields_t fields;
        logic [15:0]   raw;
    } board_word_u;

    // joystick word in game format
    // dirs at 3:0, fire 1 at bit 4, other buttons above
    typedef logic [`INPUT_LANE_BITS-1:0] lane_word_t;

endpackage

`default_nettype wire

// File: input_front.sv
`timescale 1ns/10ps
`default_nettype none

`include "input_settings.svh"

module input_front (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire                                          vs,
    input  wire                                          autofire_en,
    input  wire [15:0]                                   board_joy1,
    input  wire [15:0]                                   board_joy2,
    input  wire [15:0]                                   board_joy3,
    input  wire [15:0]                                   board_joy4,
    input  wire [9:0]                                    key_joy1,
    input  wire [9:0]                                    key_joy2,
    input  wire [9:0]                                    key_joy3,
    input  wire [3:0]                                    board_coin,
    input  wire [3:0]                                    board_start,
    input  wire [3:0]                                    key_coin,
    input  wire [3:0]                                    key_start,
    input  wire                                          key_service,
    input  wire                                          key_test,
    input  wire                                          key_pause,
    input  wire                                          osd_pause,
    input  wire                                          key_reset,
    output input_pkg::board_word_u [`INPUT_PLAYERS-1:0] joy_word,
    output logic [3:0]                                   coin_req,
    output logic [3:0]                                   start_req,
    output logic                                         service_req,
    output logic                                         test_req,
    output logic                                         pause_key,
    output logic                                         osd_req,
    output logic                                         reset_key,
    output logic                                         frame_end,
    output logic                                         fire_gate
);

    logic       vs_r;      // captured vs
    logic       vs_l;      // vs one cycle later
    logic       vs_rise;
    logic [2:0] fire_cnt;  // frames since last wrap

    assign vs_rise   = vs_r & ~vs_l;
    assign frame_end = ~vs_r & vs_l;  // end of vertical sync

    // merge keyboard mirrors into the lower ten bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy_word <= '0;
        end else begin
            joy_word[0].raw <= board_joy1 | {6'd0, key_joy1};
            joy_word[1].raw <= board_joy2 | {6'd0, key_joy2};
            joy_word[2].raw <= board_joy3 | {6'd0, key_joy3};
            joy_word[3].raw <= board_joy4;  // no key mirror for player 4
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            coin_req    <= '0;
            start_req   <= '0;
            service_req <= 1'b0;
            test_req    <= 1'b0;
            pause_key   <= 1'b0;
            osd_req     <= 1'b0;
            reset_key   <= 1'b0;
        end else begin
            coin_req    <= board_coin | key_coin;    // cabinet or keyboard
            start_req   <= board_start | key_start;
            service_req <= key_service;
            test_req    <= key_test;
            pause_key   <= key_pause;
            osd_req     <= osd_pause;
            reset_key   <= key_reset;
        end
    end

    // autofire runs at frame rate, fire allowed 2 frames out of 8
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_r      <= 1'b0;
            vs_l      <= 1'b0;
            fire_cnt  <= '0;
            fire_gate <= 1'b1;
        end else begin
            vs_r <= vs;
            vs_l <= vs_r;
            if (vs_rise) begin
                fire_cnt <= fire_cnt + 3'd1;
            end
            fire_gate <= ~autofire_en || (fire_cnt > 3'd5);
        end
    end

endmodule

`default_nettype wire

// File: joy_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "input_settings.svh"

module joy_lane (
    input  wire                     clk,
    input  wire                     rst,
    input  input_pkg::board_word_u  joy_in,
    input  wire                     en4way,
    input  wire                     rot_control,
    input  wire                     flip,
    input  wire                     fire_gate,
    output input_pkg::lane_word_t   joy_out
);

    localparam logic active_low = (`INPUT_ACTIVE_LOW != 0);

    logic [3:0] dirs;      // raw stick from the board word
    logic [5:0] buttons;
    logic       multi;     // diagonal or worse
    logic [3:0] dirs_f;    // after the 4-way filter
    logic [3:0] dirs_l;    // last filtered stick
    logic [3:0] dirs_rot;  // after monitor remap
    logic       fire1;

    assign dirs    = joy_in.fields.dirs;
    assign buttons = joy_in.fields.buttons;

    // more than one bit set
    assign multi = (dirs & (dirs - 4'd1)) != 4'd0;

    always_comb begin
        if (en4way && multi) begin
            dirs_f = dirs_l;  // keep the last single direction
        end else begin
            dirs_f = dirs;
        end
    end

    // rotated monitor, up/down trade places with left/right
    always_comb begin
        if (!rot_control) begin
            dirs_rot = dirs_f;
        end else if (flip) begin
            dirs_rot = {dirs_f[1], dirs_f[0], dirs_f[2], dirs_f[3]};
        end else begin
            dirs_rot = {dirs_f[0], dirs_f[1], dirs_f[3], dirs_f[2]};
        end
    end

    assign fire1 = buttons[0] & fire_gate;  // autofire gate

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dirs_l  <= '0;
            joy_out <= {`INPUT_LANE_BITS{active_low}};
        end else begin
            dirs_l  <= dirs_f;
            joy_out <= {`INPUT_LANE_BITS{active_low}} ^ {buttons[5:1], fire1, dirs_rot};
        end
    end

    // once the held stick is single or idle, the filter keeps it so
    a_four_way_single: assert property (
        @(posedge clk) disable iff (rst)
        en4way && $onehot0(dirs_l) |=> $onehot0(dirs_l)
    );

endmodule

`default_nettype wire

// File: input_collect.sv
`timescale 1ns/10ps
`default_nettype none

`include "input_settings.svh"

module input_collect (
    input  wire                                          clk,
    input  wire                                          rst,
    input  input_pkg::lane_word_t [`INPUT_PLAYERS-1:0]  lane_joy,
    input  input_pkg::board_word_u [`INPUT_PLAYERS-1:0] joy_word,
    input  wire [3:0]                                    coin_req,
    input  wire [3:0]                                    start_req,
    input  wire                                          service_req,
    input  wire                                          test_req,
    input  wire                                          pause_key,
    input  wire                                          osd_req,
    input  wire                                          reset_key,
    input  wire                                          frame_end,
    input  wire                                          lock,
    output input_pkg::lane_word_t                        game_joy1,
    output input_pkg::lane_word_t                        game_joy2,
    output input_pkg::lane_word_t                        game_joy3,
    output input_pkg::lane_word_t                        game_joy4,
    output logic [3:0]                                   game_coin,
    output logic [3:0]                                   game_start,
    output logic                                         game_service,
    output logic                                         game_test,
    output logic                                         game_pause,
    output logic                                         soft_rst
);

    localparam logic active_low = (`INPUT_ACTIVE_LOW != 0);

    localparam input_pkg::lane_word_t joy_idle = {`INPUT_LANE_BITS{active_low}};

    logic [3:0] joy_coin;     // coin bits from the sticks
    logic [3:0] joy_start;
    logic       joy_pause_r;  // player 1 or 2 pause bit
    logic       joy_pause_l;
    logic       pause_key_l;
    logic       osd_l;
    logic       reset_key_l;
    logic       service_l;
    logic       pause_frame;  // frame advance armed
    logic       pause_rise;
    logic       joy_pause_rise;
    logic       osd_change;
    logic       service_rise;

    always_comb begin
        for (int i = 0; i < `INPUT_PLAYERS; i++) begin
            joy_coin[i]  = joy_word[i].raw[`INPUT_COIN_BIT];
            joy_start[i] = joy_word[i].raw[`INPUT_START_BIT];
        end
    end

    assign pause_rise     = pause_key & ~pause_key_l;
    assign joy_pause_rise = joy_pause_r & ~joy_pause_l;
    assign osd_change     = osd_req ^ osd_l;
    assign service_rise   = service_req & ~service_l;

    // edge detector history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy_pause_r <= 1'b0;
            joy_pause_l <= 1'b0;
            pause_key_l <= 1'b0;
            osd_l       <= 1'b0;
            reset_key_l <= 1'b0;
            service_l   <= 1'b0;
        end else begin
            joy_pause_r <= joy_word[0].raw[`INPUT_PAUSE_BIT] | joy_word[1].raw[`INPUT_PAUSE_BIT];
            joy_pause_l <= joy_pause_r;
            pause_key_l <= pause_key;
            osd_l       <= osd_req;
            reset_key_l <= reset_key;
            service_l   <= service_req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_joy1    <= joy_idle;
            game_joy2    <= joy_idle;
            game_joy3    <= joy_idle;
            game_joy4    <= joy_idle;
            game_coin    <= {4{active_low}};
            game_start   <= {4{active_low}};
            game_service <= active_low;
            game_test    <= active_low;
            soft_rst     <= 1'b0;
        end else if (lock) begin
            game_joy1    <= joy_idle;  // locked core sees nothing pressed
            game_joy2    <= joy_idle;
            game_joy3    <= joy_idle;
            game_joy4    <= joy_idle;
            game_coin    <= {4{active_low}};
            game_start   <= {4{active_low}};
            game_service <= active_low;
            game_test    <= active_low;
            soft_rst     <= 1'b0;
        end else begin
            game_joy1    <= lane_joy[0];  // lanes already in game polarity
            game_joy2    <= lane_joy[1];
            game_joy3    <= lane_joy[2];
            game_joy4    <= lane_joy[3];
            game_coin    <= {4{active_low}} ^ (joy_coin | coin_req);
            game_start   <= {4{active_low}} ^ (joy_start | start_req);
            game_service <= active_low ^ service_req;
            game_test    <= active_low ^ test_req;
            soft_rst     <= reset_key & ~reset_key_l;
        end
    end

    // pause FSM, later checks take priority
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_pause  <= 1'b0;
            pause_frame <= 1'b0;
        end else if (lock) begin
            game_pause  <= 1'b0;
            pause_frame <= 1'b0;
        end else begin
            if (pause_rise || joy_pause_rise) begin
                game_pause <= ~game_pause;
            end
            if (osd_change) begin
                game_pause <= osd_req;  // menu overrides a toggle
            end
            if (game_pause && service_rise) begin
                game_pause  <= 1'b0;  // run one frame
                pause_frame <= 1'b1;
            end
            if (frame_end && pause_frame) begin
                game_pause  <= 1'b1;
                pause_frame <= 1'b0;
            end
        end
    end

    a_soft_rst_single: assert property (
        @(posedge clk) disable iff (rst)
        soft_rst |=> !soft_rst
    );

    a_lock_unpaused: assert property (
        @(posedge clk) disable iff (rst)
        lock |=> !game_pause
    );

endmodule

`default_nettype wire

// File: arcade_inputs.sv
`timescale 1ns/10ps
`default_nettype none

`include "input_settings.svh"

module arcade_inputs (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   vs,
    input  wire                   dip_flip,
    input  wire                   autofire_en,
    input  wire                   rot_control,
    input  wire                   en4way,
    input  wire                   lock,
    input  wire [15:0]            board_joy1,
    input  wire [15:0]            board_joy2,
    input  wire [15:0]            board_joy3,
    input  wire [15:0]            board_joy4,
    input  wire [9:0]             key_joy1,
    input  wire [9:0]             key_joy2,
    input  wire [9:0]             key_joy3,
    input  wire [3:0]             board_coin,
    input  wire [3:0]             board_start,
    input  wire [3:0]             key_coin,
    input  wire [3:0]             key_start,
    input  wire                   key_service,
    input  wire                   key_test,
    input  wire                   key_pause,
    input  wire                   osd_pause,
    input  wire                   key_reset,
    output input_pkg::lane_word_t game_joy1,
    output input_pkg::lane_word_t game_joy2,
    output input_pkg::lane_word_t game_joy3,
    output input_pkg::lane_word_t game_joy4,
    output wire [3:0]             game_coin,
    output wire [3:0]             game_start,
    output wire                   game_service,
    output wire                   game_test,
    output wire                   game_pause,
    output wire                   soft_rst
);

    input_pkg::board_word_u [`INPUT_PLAYERS-1:0] joy_word;
    input_pkg::lane_word_t  [`INPUT_PLAYERS-1:0] lane_joy;

    wire [3:0] coin_req;
    wire [3:0] start_req;
    wire       service_req;
    wire       test_req;
    wire       pause_key;
    wire       osd_req;
    wire       reset_key;
    wire       frame_end;
    wire       fire_gate;

    input_front u_front (
        .clk         (clk),
        .rst         (rst),
        .vs          (vs),
        .autofire_en (autofire_en),
        .board_joy1  (board_joy1),
        .board_joy2  (board_joy2),
        .board_joy3  (board_joy3),
        .board_joy4  (board_joy4),
        .key_joy1    (key_joy1),
        .key_joy2    (key_joy2),
        .key_joy3    (key_joy3),
        .board_coin  (board_coin),
        .board_start (board_start),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .key_service (key_service),
        .key_test    (key_test),
        .key_pause   (key_pause),
        .osd_pause   (osd_pause),
        .key_reset   (key_reset),
        .joy_word    (joy_word),
        .coin_req    (coin_req),
        .start_req   (start_req),
        .service_req (service_req),
        .test_req    (test_req),
        .pause_key   (pause_key),
        .osd_req     (osd_req),
        .reset_key   (reset_key),
        .frame_end   (frame_end),
        .fire_gate   (fire_gate)
    );

    // dip_flip set means upright cabinet, so the lanes get its inverse
    for (genvar p = 0; p < `INPUT_PLAYERS; p++) begin : g_lane
        joy_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .joy_in      (joy_word[p]),
            .en4way      (en4way),
            .rot_control (rot_control),
            .flip        (~dip_flip),
            .fire_gate   (fire_gate),
            .joy_out     (lane_joy[p])
        );
    end

    input_collect u_collect (
        .clk          (clk),
        .rst          (rst),
        .lane_joy     (lane_joy),
        .joy_word     (joy_word),
        .coin_req     (coin_req),
        .start_req    (start_req),
        .service_req  (service_req),
        .test_req     (test_req),
        .pause_key    (pause_key),
        .osd_req      (osd_req),
        .reset_key    (reset_key),
        .frame_end    (frame_end),
        .lock         (lock),
        .game_joy1    (game_joy1),
        .game_joy2    (game_joy2),
        .game_joy3    (game_joy3),
        .game_joy4    (game_joy4),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service),
        .game_test    (game_test),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst)
    );

endmodule

`default_nettype wire

// File: input_checker.sv
`timescale 1ns/10ps
`default_nettype none

module input_checker (
    input  logic         clk,
    input  logic         rst,
    input  logic         check_now,   // outputs settled for this step
    input  logic [127:0] step_name,
    input  logic [9:0]   exp_joy1,
    input  logic [9:0]   exp_joy2,
    input  logic [9:0]   exp_joy3,
    input  logic [9:0]   exp_joy4,
    input  logic [3:0]   exp_coin,
    input  logic [3:0]   exp_start,
    input  logic [2:0]   exp_misc,    // pause, test, service
    input  logic [3:0]   exp_srst,    // soft_rst cycles in the step
    input  logic [9:0]   game_joy1,
    input  logic [9:0]   game_joy2,
    input  logic [9:0]   game_joy3,
    input  logic [9:0]   game_joy4,
    input  logic [3:0]   game_coin,
    input  logic [3:0]   game_start,
    input  logic         game_service,
    input  logic         game_test,
    input  logic         game_pause,
    input  logic         soft_rst,
    output int           test_count,
    output int           error_count
);

    int srst_cnt;     // soft_rst cycles seen since the last check
    int step_errors;

    task automatic compare_value(input string field, input logic [9:0] exp,
                                 input logic [9:0] act);
        if (exp !== act) begin
            $display("** Error %0s %0s: expected %h, actual %h", step_name, field, exp, act);
            step_errors++;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            srst_cnt    = 0;
            test_count  = 0;
            error_count = 0;
        end else if (check_now) begin
            step_errors = 0;
            srst_cnt    = srst_cnt + soft_rst;
            compare_value("game_joy1", exp_joy1, game_joy1);
            compare_value("game_joy2", exp_joy2, game_joy2);
            compare_value("game_joy3", exp_joy3, game_joy3);
            compare_value("game_joy4", exp_joy4, game_joy4);
            compare_value("game_coin", {6'd0, exp_coin}, {6'd0, game_coin});
            compare_value("game_start", {6'd0, exp_start}, {6'd0, game_start});
            compare_value("pause/test/service", {7'd0, exp_misc},
                          {7'd0, game_pause, game_test, game_service});
            compare_value("soft_rst cycles", {6'd0, exp_srst}, srst_cnt[9:0]);
            test_count++;
            error_count = error_count + step_errors;
            if (step_errors == 0) begin
                $display("pass %0s", step_name);
            end
            srst_cnt = 0;
        end else begin
            srst_cnt = srst_cnt + soft_rst;  // count every high cycle
        end
    end

endmodule

`default_nettype wire

// File: tb_arcade_inputs.sv
`timescale 1ns/10ps
`default_nettype none

module tb_arcade_inputs;

    localparam int max_steps = 64;

    logic clk, rst, vs, dip_flip, autofire_en, rot_control, en4way, lock;
    logic [15:0] board_joy1, board_joy2, board_joy3, board_joy4;
    logic [9:0]  key_joy1, key_joy2, key_joy3;
    logic [3:0]  board_coin, board_start, key_coin, key_start;
    logic key_service, key_test, key_pause, osd_pause, key_reset;
    logic [9:0]  game_joy1, game_joy2, game_joy3, game_joy4;
    logic [3:0]  game_coin, game_start;
    logic game_service, game_test, game_pause, soft_rst;

    // one entry per file line
    logic [127:0] names[max_steps];
    int           holds[max_steps], pulses[max_steps];
    logic [4:0]   ctrls[max_steps], keys[max_steps];
    logic [15:0]  bj1[max_steps], bj2[max_steps], bj3[max_steps], bj4[max_steps];
    logic [9:0]   kj1[max_steps], kj2[max_steps], kj3[max_steps];
    logic [3:0]   bcoin[max_steps], bstart[max_steps], kcoin[max_steps], kstart[max_steps];
    logic [9:0]   ej1[max_steps], ej2[max_steps], ej3[max_steps], ej4[max_steps];
    logic [3:0]   ecoin[max_steps], estart[max_steps], esrst[max_steps];
    logic [2:0]   emisc[max_steps];

    int   nsteps;
    int   cur;
    int   limit_cycles;
    logic loaded;
    logic check_now;
    int   test_count, error_count;

    arcade_inputs DUT (.*);

    input_checker u_checker (
        .clk(clk), .rst(rst), .check_now(check_now), .step_name(names[cur]),
        .exp_joy1(ej1[cur]), .exp_joy2(ej2[cur]), .exp_joy3(ej3[cur]), .exp_joy4(ej4[cur]),
        .exp_coin(ecoin[cur]), .exp_start(estart[cur]), .exp_misc(emisc[cur]),
        .exp_srst(esrst[cur]), .game_joy1(game_joy1), .game_joy2(game_joy2),
        .game_joy3(game_joy3), .game_joy4(game_joy4), .game_coin(game_coin),
        .game_start(game_start), .game_service(game_service), .game_test(game_test),
        .game_pause(game_pause), .soft_rst(soft_rst),
        .test_count(test_count), .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("input_vectors_input.txt", "r");
        if (fd == 0) begin
            $display("could not open input_vectors_input.txt");
        end else begin
            while (!$feof(fd) && nsteps < max_steps) begin
                if ($fgets(line, fd) == 0) continue;
                if (line.len() < 2 || line.getc(0) == "#") continue;  // comment or blank
                n = $sscanf(line,
                    "%s %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    names[nsteps], holds[nsteps], pulses[nsteps], ctrls[nsteps],
                    bj1[nsteps], bj2[nsteps], bj3[nsteps], bj4[nsteps],
                    kj1[nsteps], kj2[nsteps], kj3[nsteps], bcoin[nsteps], bstart[nsteps],
                    kcoin[nsteps], kstart[nsteps], keys[nsteps], ej1[nsteps], ej2[nsteps],
                    ej3[nsteps], ej4[nsteps], ecoin[nsteps], estart[nsteps], emisc[nsteps],
                    esrst[nsteps]);
                if (n == 24) begin
                    limit_cycles = limit_cycles + holds[nsteps] + 4 * pulses[nsteps] + 1;
                    nsteps++;
                end
            end
            $fclose(fd);
        end
    endtask

    // upper board bits are unused by games, so they carry noise
    task automatic apply_step(input int i);
        {lock, en4way, rot_control, autofire_en, dip_flip} <= ctrls[i];
        board_joy1  <= bj1[i] | {6'($urandom), 10'd0};
        board_joy2  <= bj2[i] | {6'($urandom), 10'd0};
        board_joy3  <= bj3[i] | {6'($urandom), 10'd0};
        board_joy4  <= bj4[i] | {6'($urandom), 10'd0};
        key_joy1    <= kj1[i];
        key_joy2    <= kj2[i];
        key_joy3    <= kj3[i];
        board_coin  <= bcoin[i];
        board_start <= bstart[i];
        key_coin    <= kcoin[i];
        key_start   <= kstart[i];
        {key_reset, osd_pause, key_pause, key_test, key_service} <= keys[i];
    endtask

    initial begin
        void'($urandom(24));
        {rst, vs, dip_flip, autofire_en, rot_control, en4way, lock} = 7'b1000000;
        {board_joy1, board_joy2, board_joy3, board_joy4} = '0;
        {key_joy1, key_joy2, key_joy3} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        {key_service, key_test, key_pause, osd_pause, key_reset} = '0;
        check_now = 1'b0;
        cur = 0;
        nsteps = 0;
        limit_cycles = 0;
        loaded = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < nsteps; i++) begin
            cur <= i;  // checker still sees the previous step on this edge
            apply_step(i);
            for (int p = 0; p < pulses[i]; p++) begin
                @(posedge clk) vs <= 1'b1;  // two cycles high, two low
                @(posedge clk);
                @(posedge clk) vs <= 1'b0;
                @(posedge clk);
            end
            repeat (holds[i]) @(posedge clk);
            check_now <= 1'b1;
            @(posedge clk);
            check_now <= 1'b0;
        end
        repeat (2) @(posedge clk);
        $display("tests %0d, errors %0d", test_count, error_count);
        if (nsteps > 0 && error_count == 0 && test_count == nsteps) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the step lengths in the file
    initial begin
        wait (loaded);
        #(limit_cycles * 4 + 400);
        $display("watchdog expired before all steps finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: input_vectors_input.txt
# name hold pulses ctrl{lock,en4way,rot,afire,dip_flip} bj1 bj2 bj3 bj4 kj1 kj2 kj3 bcoin bstart kcoin kstart keys{reset,osd,pause,test,service}
# expected: joy1 joy2 joy3 joy4 coin start misc{pause,test,service} soft_rst_cycles
idle         6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
merge_dirs   6 0 01 0001 0010 0000 0004 002 000 008 0 0 0 0 00 3fc 3ef 3f7 3fb f f 3 0
merge_btn    6 0 01 0020 0000 0000 0000 000 010 000 0 0 0 0 00 3df 3ef 3ff 3ff f f 3 0
coin_start   6 0 01 0080 0000 0040 0000 000 000 000 2 0 0 8 00 37f 3ff 3bf 3ff c 3 3 0
service_test 6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 03 3ff 3ff 3ff 3ff f f 0 0
release      6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
four_way     6 0 09 0008 0000 0000 0000 000 000 000 0 0 0 0 00 3f7 3ff 3ff 3ff f f 3 0
four_diag    6 0 09 000a 0000 0000 0000 000 000 000 0 0 0 0 00 3f7 3ff 3ff 3ff f f 3 0
diag_free    6 0 01 000a 0000 0000 0000 000 000 000 0 0 0 0 00 3f5 3ff 3ff 3ff f f 3 0
rot          6 0 05 0008 0001 0000 0000 000 000 000 0 0 0 0 00 3fd 3f7 3ff 3ff f f 3 0
rot_flip     6 0 04 0008 0002 0004 0000 000 000 000 0 0 0 0 00 3fe 3f7 3fd 3ff f f 3 0
rot_off      6 0 00 0008 0000 0000 0000 000 000 000 0 0 0 0 00 3f7 3ff 3ff 3ff f f 3 0
afire_cnt0   6 0 03 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
afire_cnt5   6 5 03 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
afire_cnt6   6 1 03 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ef 3ff 3ff 3ff f f 3 0
afire_cnt7   6 1 03 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ef 3ff 3ff 3ff f f 3 0
afire_wrap   6 1 03 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
afire_off    6 0 01 0010 0000 0000 0000 000 000 000 0 0 0 0 00 3ef 3ff 3ff 3ff f f 3 0
pause_key    6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 04 3ff 3ff 3ff 3ff f f 7 0
pause_rel    6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 7 0
pause_key2   6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 04 3ff 3ff 3ff 3ff f f 3 0
pause_joy1   6 0 01 0100 0000 0000 0000 000 000 000 0 0 0 0 00 2ff 3ff 3ff 3ff f f 7 0
joy1_rel     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 7 0
pause_joy2   6 0 01 0000 0100 0000 0000 000 000 000 0 0 0 0 00 3ff 2ff 3ff 3ff f f 3 0
joy2_rel     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
osd_on       6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 08 3ff 3ff 3ff 3ff f f 7 0
osd_key      6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 0c 3ff 3ff 3ff 3ff f f 3 0
osd_off      6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
osd_both     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 0c 3ff 3ff 3ff 3ff f f 7 0
osd_both_off 6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
fa_pause     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 04 3ff 3ff 3ff 3ff f f 7 0
fa_service   6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 05 3ff 3ff 3ff 3ff f f 2 0
fa_frame     6 1 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 7 0
fa_idle      6 1 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 7 0
fa_unpause   6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 04 3ff 3ff 3ff 3ff f f 3 0
fa_rel       6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
soft_rst     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 10 3ff 3ff 3ff 3ff f f 3 1
soft_hold    6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 10 3ff 3ff 3ff 3ff f f 3 0
soft_rel     6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0
pause_set    6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 04 3ff 3ff 3ff 3ff f f 7 0
lock         6 0 11 0013 0080 0040 0100 001 000 000 f f 0 0 07 3ff 3ff 3ff 3ff f f 3 0
unlock       6 0 01 0000 0000 0000 0000 000 000 000 0 0 0 0 00 3ff 3ff 3ff 3ff f f 3 0

// File: vlog.f
+incdir+.
input_pkg.sv
input_front.sv
joy_lane.sv
input_collect.sv
arcade_inputs.sv
input_checker.sv
tb_arcade_inputs.sv

// File: Bender.yml
package:
  name: arcade_inputs

sources:
  - include_dirs:
      - .
    files:
      - input_pkg.sv
      - input_front.sv
      - joy_lane.sv
      - input_collect.sv
      - arcade_inputs.sv
  - target: test
    include_dirs:
      - .
    files:
      - input_checker.sv
      - tb_arcade_inputs.sv
